// ==== conv_pkg.sv ====
`default_nettype none

package conv_pkg;

    // ========================================
    // Frame and kernel geometry
    // ========================================

    localparam int IMG_WIDTH  = 16;
    localparam int IMG_HEIGHT = 8;
    localparam int KERNEL_H   = 3;
    localparam int KERNEL_W   = 3;

    // Pixel and coefficient word width, fixed point split
    localparam int W      = 8;
    localparam int W_FRAC = 0;

    localparam int NUM_TAPS = KERNEL_H * KERNEL_W;
    localparam int X_BITS   = $clog2(IMG_WIDTH);
    localparam int Y_BITS   = $clog2(IMG_HEIGHT);

    // Room for NUM_TAPS full products plus sign
    localparam int ACC_W = $clog2(NUM_TAPS) + 2 * W + 1;

    // Coefficient address is row * KERNEL_W + column
    localparam int COEF_ADDR_BITS = 4;

    // ========================================
    // Data types
    // ========================================

    typedef logic signed [W-1:0] pixel_t;
    typedef logic signed [W-1:0] coef_t;

    // Row 0 / column 0 is the tap on the current pixel
    typedef coef_t  [KERNEL_H-1:0][KERNEL_W-1:0] kernel_t;
    typedef pixel_t [KERNEL_H-1:0][KERNEL_W-1:0] window_t;

    typedef struct packed {
        logic [X_BITS-1:0] x;
        logic [Y_BITS-1:0] y;
    } pos_t;

    typedef logic signed [ACC_W-1:0] acc_t;

    // Window stage handed from line_window to mac_stage
    typedef struct packed {
        logic    valid;
        logic    border;
        window_t window;
        pixel_t  pixel;
    } win_stage_t;

    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } fsm_state_t;

endpackage

`default_nettype wire

// ==== scan_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_counter (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           accept,
    output conv_pkg::pos_t pos,
    output logic           border,
    output logic           last_pixel
);

    logic x_at_end;
    logic y_at_end;

    assign x_at_end = (pos.x == conv_pkg::X_BITS'(conv_pkg::IMG_WIDTH - 1));
    assign y_at_end = (pos.y == conv_pkg::Y_BITS'(conv_pkg::IMG_HEIGHT - 1));

    // Raster scan, x across the row then y down the frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos <= '0;
        end else if (accept) begin
            if (x_at_end) begin
                pos.x <= '0;
                // Wrap to the top once the frame is finished
                if (y_at_end) begin
                    pos.y <= '0;
                end else begin
                    pos.y <= pos.y + 1'b1;
                end
            end else begin
                pos.x <= pos.x + 1'b1;
            end
        end
    end

    // Window not yet filled with real pixels
    assign border = (pos.x < conv_pkg::X_BITS'(conv_pkg::KERNEL_W - 1)) ||
                    (pos.y < conv_pkg::Y_BITS'(conv_pkg::KERNEL_H - 1));

    // Bottom right corner
    assign last_pixel = x_at_end && y_at_end;

endmodule

`default_nettype wire

// ==== frame_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_ctrl_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic accept,
    input  logic last_pixel,
    output logic running,
    output logic load_en,
    output logic frame_done
);

    conv_pkg::fsm_state_t state;
    conv_pkg::fsm_state_t state_next;

    logic frame_end;

    // Final pixel of the frame changes hands this cycle
    assign frame_end = accept && last_pixel;

    // ========================================
    // Next state
    // ========================================

    always_comb begin
        state_next = state;
        case (state)
            conv_pkg::IDLE: begin
                if (start) begin
                    state_next = conv_pkg::RUN;
                end
            end
            conv_pkg::RUN: begin
                // Start pulses are ignored here
                if (frame_end) begin
                    state_next = conv_pkg::IDLE;
                end
            end
            default: begin
                state_next = conv_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= conv_pkg::IDLE;
            frame_done <= 1'b0;
        end else begin
            state <= state_next;
            // Pulse lands on the same edge as the return to IDLE
            frame_done <= (state == conv_pkg::RUN) && frame_end;
        end
    end

    // Pixels only while running, kernel writes only while idle
    assign running = (state == conv_pkg::RUN);
    assign load_en = (state == conv_pkg::IDLE);

endmodule

`default_nettype wire

// ==== kernel_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module kernel_regs (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                load_en,
    input  logic                                coef_wr,
    input  logic [conv_pkg::COEF_ADDR_BITS-1:0] coef_addr,
    input  conv_pkg::coef_t                     coef_data,
    output conv_pkg::kernel_t                   kernel
);

    logic wr_en;

    // Writes during a frame are dropped, so the kernel stays fixed
    assign wr_en = load_en && coef_wr;

    // One register per tap, address = row * KERNEL_W + col
    // Addresses past the last tap match nothing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kernel <= '0;
        end else if (wr_en) begin
            for (int r = 0; r < conv_pkg::KERNEL_H; r++) begin
                for (int c = 0; c < conv_pkg::KERNEL_W; c++) begin
                    if (coef_addr ==
                        conv_pkg::COEF_ADDR_BITS'(r * conv_pkg::KERNEL_W + c)) begin
                        kernel[r][c] <= coef_data;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== line_window.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_window (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 accept,
    input  logic                 advance,
    input  conv_pkg::pixel_t     x_data,
    input  conv_pkg::pos_t       pos,
    input  logic                 border,
    output conv_pkg::win_stage_t stage
);

    // ========================================
    // Line buffers
    // ========================================

    // Window row 0 comes straight from the input pixel
    // Buffer r holds the pixel r+1 rows up at each column
    conv_pkg::pixel_t line_buf [conv_pkg::KERNEL_H-1][conv_pkg::IMG_WIDTH];

    always_ff @(posedge clk) begin
        if (accept) begin
            // Rows move down one slot, newest row on top
            for (int r = conv_pkg::KERNEL_H - 2; r > 0; r--) begin
                line_buf[r][pos.x] <= line_buf[r-1][pos.x];
            end
            line_buf[0][pos.x] <= x_data;
        end
    end

    // ========================================
    // Sliding window
    // ========================================

    conv_pkg::window_t win_q;
    conv_pkg::window_t win_next;

    // Window as it looks with the current pixel taken in
    always_comb begin
        win_next = win_q;
        for (int r = 0; r < conv_pkg::KERNEL_H; r++) begin
            // Older columns step one place left
            for (int c = conv_pkg::KERNEL_W - 1; c > 0; c--) begin
                win_next[r][c] = win_q[r][c-1];
            end
        end
        // New column: current pixel over the buffered rows above it
        win_next[0][0] = x_data;
        for (int r = 1; r < conv_pkg::KERNEL_H; r++) begin
            win_next[r][0] = line_buf[r-1][pos.x];
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            win_q <= win_next;
        end
    end

    // ========================================
    // Stage register
    // ========================================

    logic              valid_q;
    logic              border_q;
    conv_pkg::window_t stage_win_q;
    conv_pkg::pixel_t  pixel_q;

    // Empty slot when the pipeline moves without a new pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            border_q    <= border;
            stage_win_q <= win_next;
            pixel_q     <= x_data;
        end
    end

    assign stage = '{valid: valid_q, border: border_q, window: stage_win_q, pixel: pixel_q};

endmodule

`default_nettype wire

// ==== mac_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 advance,
    input  conv_pkg::win_stage_t stage,
    input  conv_pkg::kernel_t    kernel,
    output logic                 y_valid,
    output conv_pkg::pixel_t     y_data
);

    // ========================================
    // Products
    // ========================================

    logic signed [2*conv_pkg::W-1:0] prod [conv_pkg::KERNEL_H][conv_pkg::KERNEL_W];

    // Full width signed product per tap
    always_comb begin
        for (int r = 0; r < conv_pkg::KERNEL_H; r++) begin
            for (int c = 0; c < conv_pkg::KERNEL_W; c++) begin
                prod[r][c] = signed'(stage.window[r][c]) * signed'(kernel[r][c]);
            end
        end
    end

    // ========================================
    // Accumulate and truncate
    // ========================================

    conv_pkg::acc_t   acc;
    conv_pkg::pixel_t conv_result;

    always_comb begin
        acc = '0;
        for (int r = 0; r < conv_pkg::KERNEL_H; r++) begin
            for (int c = 0; c < conv_pkg::KERNEL_W; c++) begin
                // Sign extended into the accumulator
                acc = acc + conv_pkg::acc_t'(prod[r][c]);
            end
        end
    end

    // Drop fractional bits, upper bits wrap away
    assign conv_result = conv_pkg::pixel_t'(acc[conv_pkg::W+conv_pkg::W_FRAC-1:conv_pkg::W_FRAC]);

    // ========================================
    // Output register
    // ========================================

    // Holds while the consumer stalls us
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y_valid <= 1'b0;
        end else if (advance) begin
            y_valid <= stage.valid;
        end
    end

    // Border pixels go out unchanged
    always_ff @(posedge clk) begin
        if (advance) begin
            if (stage.border) begin
                y_data <= stage.pixel;
            end else begin
                y_data <= conv_result;
            end
        end
    end

endmodule

`default_nettype wire

// ==== conv_filter_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_filter_top (
    input  logic                                clk,
    input  logic                                rst_n,
    // Kernel load, honoured in IDLE only
    input  logic                                coef_wr,
    input  logic [conv_pkg::COEF_ADDR_BITS-1:0] coef_addr,
    input  conv_pkg::coef_t                     coef_data,
    input  logic                                start,
    // Pixel in
    input  logic                                x_valid,
    output logic                                x_ready,
    input  conv_pkg::pixel_t                    x_data,
    // Pixel out
    output logic                                y_valid,
    input  logic                                y_ready,
    output conv_pkg::pixel_t                    y_data,
    output logic                                frame_done
);

    logic                 advance;
    logic                 accept;
    logic                 running;
    logic                 load_en;
    logic                 border;
    logic                 last_pixel;
    conv_pkg::pos_t       pos;
    conv_pkg::kernel_t    kernel;
    conv_pkg::win_stage_t stage;

    // Whole pipeline moves together, or not at all
    assign advance = y_ready || !y_valid;
    assign x_ready = advance && running;
    assign accept  = x_valid && x_ready;

    scan_counter u_scan (
        .clk        (clk),
        .rst_n      (rst_n),
        .accept     (accept),
        .pos        (pos),
        .border     (border),
        .last_pixel (last_pixel)
    );

    frame_ctrl_fsm u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .accept     (accept),
        .last_pixel (last_pixel),
        .running    (running),
        .load_en    (load_en),
        .frame_done (frame_done)
    );

    kernel_regs u_kernel (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .coef_wr   (coef_wr),
        .coef_addr (coef_addr),
        .coef_data (coef_data),
        .kernel    (kernel)
    );

    line_window u_window (
        .clk     (clk),
        .rst_n   (rst_n),
        .accept  (accept),
        .advance (advance),
        .x_data  (x_data),
        .pos     (pos),
        .border  (border),
        .stage   (stage)
    );

    mac_stage u_mac (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .stage   (stage),
        .kernel  (kernel),
        .y_valid (y_valid),
        .y_data  (y_data)
    );

endmodule

`default_nettype wire

// ==== tb_conv_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_conv_filter;

    localparam int NUM_PIX        = conv_pkg::IMG_WIDTH * conv_pkg::IMG_HEIGHT;
    localparam int NUM_ENTRIES    = 6;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * (NUM_PIX * 4 + 200);
    localparam int MODE_RAMP      = 1;
    localparam int MODE_CONST     = 2;

    typedef struct packed {
        conv_pkg::kernel_t                   kernel;
        int                                  mode;
        int                                  stall_pct;
        logic [conv_pkg::COEF_ADDR_BITS-1:0] run_addr;
        conv_pkg::coef_t                     run_data;
    } test_entry_t;

    // Taps 0..8 (row*3+col), mode (0 random, 1 ramp, 2 const), stall %, RUN addr, RUN data
    int test_tab [NUM_ENTRIES][13] = '{
        '{1, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 5},
        '{1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 30, 4, -3},
        '{1, 1, 1, 1, 1, 1, 1, 1, 1, 0, 0, 8, 2},
        '{1, 1, 1, 1, 1, 1, 1, 1, 1, 2, 40, 1, -1},
        '{1, -2, 1, -2, 4, -2, 1, -2, 1, 0, 50, 4, 0},
        '{-1, 3, -5, 7, -9, 11, -13, 15, -17, 1, 20, 2, 127}
    };

    logic                                clk = 1'b0;
    logic                                rst_n = 1'b0;
    logic                                coef_wr = 1'b0;
    logic [conv_pkg::COEF_ADDR_BITS-1:0] coef_addr = '0;
    conv_pkg::coef_t                     coef_data = '0;
    logic                                start = 1'b0;
    logic                                x_valid = 1'b0;
    logic                                x_ready;
    conv_pkg::pixel_t                    x_data = '0;
    logic                                y_valid;
    logic                                y_ready = 1'b0;
    conv_pkg::pixel_t                    y_data;
    logic                                frame_done;

    // Frame under test and expected outputs of all frames in order
    conv_pkg::pixel_t img [NUM_PIX];
    conv_pkg::pixel_t exp_mem [NUM_ENTRIES * NUM_PIX];
    int               exp_total = 0;
    int               in_cycle_q [$];
    int               in_count = 0;
    int               last_in_cycle = 0;
    int               cycle = 0;
    int               out_count = 0;
    int               done_count = 0;
    int               cur_stall = 0;
    int               pix_errors = 0;
    int               lat_errors = 0;
    int               proto_errors = 0;
    int               ctrl_errors = 0;
    logic             idle_phase = 1'b1;
    logic             in_fire = 1'b0;

    conv_filter_top dut_i (.*);

    always #4 clk = ~clk;

    // Consumer stalls with the entry's probability
    always @(posedge clk) begin
        y_ready <= (int'($urandom_range(99)) >= cur_stall);
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: run not finished after %0d cycles", TIMEOUT_CYCLES);
            report_counts();
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ========================================
    // Reference model and table helpers
    // ========================================

    function automatic test_entry_t entry_from_row(input int row);
        test_entry_t e;
        for (int r = 0; r < conv_pkg::KERNEL_H; r++) begin
            for (int c = 0; c < conv_pkg::KERNEL_W; c++) begin
                e.kernel[r][c] = conv_pkg::coef_t'(test_tab[row][r * conv_pkg::KERNEL_W + c]);
            end
        end
        e.mode      = test_tab[row][9];
        e.stall_pct = test_tab[row][10];
        e.run_addr  = conv_pkg::COEF_ADDR_BITS'(test_tab[row][11]);
        e.run_data  = conv_pkg::coef_t'(test_tab[row][12]);
        return e;
    endfunction

    function automatic conv_pkg::pixel_t make_pixel(input int mode, input int idx);
        case (mode)
            MODE_RAMP:  return conv_pkg::pixel_t'(idx * 3 + 1);
            MODE_CONST: return conv_pkg::pixel_t'(100);
            default:    return conv_pkg::pixel_t'($urandom);
        endcase
    endfunction

    // Tap r/c weights the pixel r rows up and c columns left
    function automatic conv_pkg::pixel_t expected_pixel(input conv_pkg::kernel_t k, input int idx);
        int x;
        int y;
        int sum;
        x = idx % conv_pkg::IMG_WIDTH;
        y = idx / conv_pkg::IMG_WIDTH;
        // Border pixels pass through untouched
        if (x < conv_pkg::KERNEL_W - 1 || y < conv_pkg::KERNEL_H - 1) begin
            return img[idx];
        end
        sum = 0;
        for (int r = 0; r < conv_pkg::KERNEL_H; r++) begin
            for (int c = 0; c < conv_pkg::KERNEL_W; c++) begin
                sum += int'(img[idx - r * conv_pkg::IMG_WIDTH - c]) * int'(k[r][c]);
            end
        end
        // Truncation lets the upper bits wrap away
        return conv_pkg::pixel_t'(sum >>> conv_pkg::W_FRAC);
    endfunction

    // ========================================
    // Compare tasks
    // ========================================

    task automatic check_pixel(input conv_pkg::pixel_t got, input conv_pkg::pixel_t expected,
                               input int idx);
        if (got !== expected) begin
            pix_errors++;
            $display("mismatch at %0t: output %0d is %0d, expected %0d", $time, idx, got, expected);
        end
    endtask

    task automatic check_latency(input int got, input int expected);
        if (got != expected) begin
            lat_errors++;
            $display("mismatch at %0t: latency %0d edges, expected %0d", $time, got, expected);
        end
    endtask

    task automatic check_frame_done(input int got, input int expected);
        if (got != expected) begin
            ctrl_errors++;
            $display("mismatch at %0t: %0d frame_done pulses, expected %0d", $time, got, expected);
        end
    endtask

    task automatic report_counts();
        $display("errors: pixel %0d, latency %0d, protocol %0d, control %0d",
                 pix_errors, lat_errors, proto_errors, ctrl_errors);
    endtask

    // Both handshakes are settled by the falling edge
    always @(negedge clk) begin
        int lat;
        in_fire = x_valid && x_ready;
        if (idle_phase && x_ready) begin
            proto_errors++;
            $display("x_ready is high while the filter should be idle, at %0t", $time);
        end
        if (in_fire) begin
            in_cycle_q.push_back(cycle);
            in_count++;
            last_in_cycle = cycle;
        end
        if (y_valid && y_ready) begin
            if (out_count >= exp_total || in_cycle_q.size() == 0) begin
                proto_errors++;
                $display("output %0d has no input pixel to match, at %0t", out_count, $time);
            end else begin
                check_pixel(y_data, exp_mem[out_count], out_count);
                lat = cycle - in_cycle_q.pop_front();
                // Fixed latency only holds with the consumer never stalling
                if (cur_stall == 0) begin
                    check_latency(lat, 2);
                end
            end
            out_count++;
        end
        if (frame_done) begin
            done_count++;
            // Pulse follows the edge that took the last pixel of the frame
            if (in_count != done_count * NUM_PIX || last_in_cycle != cycle - 1) begin
                ctrl_errors++;
                $display("frame_done pulse does not follow the last pixel of a frame, at %0t",
                         $time);
            end
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    task automatic write_kernel(input conv_pkg::kernel_t k);
        for (int r = 0; r < conv_pkg::KERNEL_H; r++) begin
            for (int c = 0; c < conv_pkg::KERNEL_W; c++) begin
                @(posedge clk);
                coef_wr   <= 1'b1;
                coef_addr <= conv_pkg::COEF_ADDR_BITS'(r * conv_pkg::KERNEL_W + c);
                coef_data <= k[r][c];
            end
        end
        @(posedge clk);
        coef_wr <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start      <= 1'b1;
        idle_phase = 1'b0;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // Raster order with random gaps and one ignored kernel write mid-frame
    task automatic drive_frame(input test_entry_t ent);
        int   sent;
        logic wrote;
        sent  = 0;
        wrote = 1'b0;
        while (sent < NUM_PIX) begin
            @(posedge clk);
            if (in_fire) begin
                sent++;
            end
            coef_wr <= 1'b0;
            if (sent == NUM_PIX / 2 && !wrote) begin
                coef_wr   <= 1'b1;
                coef_addr <= ent.run_addr;
                coef_data <= ent.run_data;
                wrote = 1'b1;
            end
            if (sent == NUM_PIX) begin
                x_valid <= 1'b0;
            end else begin
                // Offered pixel holds until taken
                if (!x_valid || in_fire) begin
                    x_valid <= ($urandom_range(3) != 0);
                end
                x_data <= img[sent];
            end
        end
    endtask

    initial begin
        test_entry_t ent;
        int          out_base;
        int          done_base;
        void'($urandom(18));
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (x_ready || y_valid || frame_done) begin
            ctrl_errors++;
            $display("handshake outputs are not low after reset, at %0t", $time);
        end
        for (int t = 0; t < NUM_ENTRIES; t++) begin
            ent       = entry_from_row(t);
            cur_stall = ent.stall_pct;
            for (int i = 0; i < NUM_PIX; i++) begin
                img[i] = make_pixel(ent.mode, i);
            end
            for (int i = 0; i < NUM_PIX; i++) begin
                exp_mem[exp_total + i] = expected_pixel(ent.kernel, i);
            end
            exp_total += NUM_PIX;
            out_base  = out_count;
            done_base = done_count;
            write_kernel(ent.kernel);
            pulse_start();
            drive_frame(ent);
            // Drain the pipeline and then look for stray outputs
            while (done_count == done_base || out_count < out_base + NUM_PIX) begin
                @(posedge clk);
            end
            repeat (4) @(posedge clk);
            if (out_count - out_base != NUM_PIX) begin
                ctrl_errors++;
                $display("frame %0d gave %0d outputs for %0d inputs", t, out_count - out_base,
                         NUM_PIX);
            end
            idle_phase = 1'b1;
        end
        check_frame_done(done_count, NUM_ENTRIES);
        report_counts();
        if (pix_errors + lat_errors + proto_errors + ctrl_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
conv_pkg.sv
scan_counter.sv
frame_ctrl_fsm.sv
kernel_regs.sv
line_window.sv
mac_stage.sv
conv_filter_top.sv
tb_conv_filter.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_conv_filter
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -F '*** FAILED ***' $(LOG) || ! grep -q -F '*** PASSED ***' $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
